//--- common/axi_lite_pkg.sv
package axi_lite_pkg;

    localparam int AXIL_ADDR_W = 32;
    localparam int AXIL_DATA_W = 32;

    // instruction access, privileged, secure
    localparam logic [2:0] AXIL_PROT_IFETCH = 3'b101;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // read address channel, master to slave
    typedef struct packed {
        logic                   valid;
        logic [AXIL_ADDR_W-1:0] addr;
        logic [2:0]             prot;
    } axil_ar_t;

    typedef struct packed {
        logic                   valid;
        logic [AXIL_DATA_W-1:0] data;
        axi_resp_e              resp;
    } axil_r_t;

endpackage

//--- common/la_isa_pkg.sv
package la_isa_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 1 << REG_ADDR_W;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;

    ////////////////////////////////////////////////////////////////////////////
    // operations kept from LA32R
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_ADDI,
        OP_ORI,
        OP_LU12I,
        OP_BEQ,
        OP_BNE,
        OP_B,
        OP_ILLEGAL     // anything else, retires as a no-op
    } op_e;

    // decode to execute
    typedef struct packed {
        logic     valid;
        word_t    pc;
        op_e      op;
        reg_idx_t rd;
        word_t    rj_val;
        word_t    rkd_val;   // rk, or rd for beq/bne
        word_t    imm;
        logic     we;
    } decoded_t;

    // retired instruction, one per cycle at most
    typedef struct packed {
        logic     valid;
        word_t    pc;
        logic     we;
        reg_idx_t rd;
        word_t    wdata;
    } commit_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

endpackage

//--- decode/decode_stage.sv
module decode_stage
    import la_isa_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_arst_n,
    input  logic      i_instr_valid,
    input  word_t     i_instr_pc,
    input  word_t     i_instr,
    input  logic      i_instr_err,
    input  redirect_t i_redirect,
    output reg_idx_t  o_raddr_a,
    output reg_idx_t  o_raddr_b,
    input  word_t     i_rdata_a,
    input  word_t     i_rdata_b,
    output decoded_t  o_dec
);

    ////////////////////////////////////////////////////////////////////////////
    // LA32R opcode fields
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [16:0] OPC_ADD_W  = 17'h00020;   // instr[31:15], 3R
    localparam logic [16:0] OPC_SUB_W  = 17'h00022;
    localparam logic [16:0] OPC_SLT    = 17'h00024;
    localparam logic [16:0] OPC_AND    = 17'h00029;
    localparam logic [16:0] OPC_OR     = 17'h0002a;
    localparam logic [16:0] OPC_XOR    = 17'h0002b;
    localparam logic [9:0]  OPC_ADDI_W = 10'h00a;     // instr[31:22], 2RI12
    localparam logic [9:0]  OPC_ORI    = 10'h00e;
    localparam logic [6:0]  OPC_LU12I  = 7'b0001010;  // instr[31:25]
    localparam logic [5:0]  OPC_B      = 6'b010100;   // instr[31:26]
    localparam logic [5:0]  OPC_BEQ    = 6'b010110;
    localparam logic [5:0]  OPC_BNE    = 6'b010111;

    op_e      op;
    reg_idx_t rd;
    reg_idx_t rj;
    reg_idx_t rk;
    word_t    imm;
    logic     is_cbranch;
    decoded_t dec_d;
    decoded_t dec_q;
    logic     valid_q;

    assign rd = i_instr[4:0];
    assign rj = i_instr[9:5];
    assign rk = i_instr[14:10];

    always_comb begin
        op = OP_ILLEGAL;
        case (i_instr[31:15])
            OPC_ADD_W: op = OP_ADD;
            OPC_SUB_W: op = OP_SUB;
            OPC_SLT:   op = OP_SLT;
            OPC_AND:   op = OP_AND;
            OPC_OR:    op = OP_OR;
            OPC_XOR:   op = OP_XOR;
            default:   ;
        endcase
        case (i_instr[31:22])
            OPC_ADDI_W: op = OP_ADDI;
            OPC_ORI:    op = OP_ORI;
            default:    ;
        endcase
        if (i_instr[31:25] == OPC_LU12I) begin
            op = OP_LU12I;
        end
        case (i_instr[31:26])
            OPC_B:   op = OP_B;
            OPC_BEQ: op = OP_BEQ;
            OPC_BNE: op = OP_BNE;
            default: ;
        endcase
        if (i_instr_err) begin
            op = OP_ILLEGAL;   // bad fetch response
        end
    end

    // immediates
    always_comb begin
        case (op)
            OP_ADDI:         imm = {{20{i_instr[21]}}, i_instr[21:10]};
            OP_ORI:          imm = {20'b0, i_instr[21:10]};
            OP_LU12I:        imm = {i_instr[24:5], 12'b0};
            OP_BEQ, OP_BNE:  imm = {{14{i_instr[25]}}, i_instr[25:10], 2'b00};
            OP_B:            imm = {{4{i_instr[9]}}, i_instr[9:0], i_instr[25:10], 2'b00};
            default:         imm = '0;
        endcase
    end

    assign is_cbranch = (op == OP_BEQ) || (op == OP_BNE);
    assign o_raddr_a  = rj;
    assign o_raddr_b  = is_cbranch ? rd : rk;   // beq/bne compare rj with rd

    always_comb begin
        dec_d.valid   = i_instr_valid && !i_redirect.valid;
        dec_d.pc      = i_instr_pc;
        dec_d.op      = op;
        dec_d.rd      = rd;
        dec_d.rj_val  = i_rdata_a;
        dec_d.rkd_val = i_rdata_b;
        dec_d.imm     = imm;
        // r0 writes change nothing, so they retire without we
        dec_d.we      = (op <= OP_LU12I) && (rd != '0);
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= dec_d.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_instr_valid) begin
            dec_q <= dec_d;
        end
    end

    always_comb begin
        o_dec       = dec_q;
        o_dec.valid = valid_q;
    end

endmodule

//--- execute/execute_stage.sv
module execute_stage
    import la_isa_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_arst_n,
    input  decoded_t  i_dec,
    output redirect_t o_redirect,
    output logic      o_we,
    output reg_idx_t  o_waddr,
    output word_t     o_wdata,
    output commit_t   o_commit
);

    word_t   a;
    word_t   b;
    word_t   alu_res;
    logic    taken;
    commit_t commit_d;
    commit_t commit_q;
    logic    valid_q;

    assign a = i_dec.rj_val;
    assign b = i_dec.rkd_val;

    ////////////////////////////////////////////////////////////////////////////
    // ALU and branch compare
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (i_dec.op)
            OP_ADD:   alu_res = a + b;
            OP_SUB:   alu_res = a - b;
            OP_AND:   alu_res = a & b;
            OP_OR:    alu_res = a | b;
            OP_XOR:   alu_res = a ^ b;
            OP_SLT:   alu_res = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            OP_ADDI:  alu_res = a + i_dec.imm;
            OP_ORI:   alu_res = a | i_dec.imm;
            OP_LU12I: alu_res = i_dec.imm;
            default:  alu_res = '0;   // branches and illegal write nothing
        endcase
    end

    always_comb begin
        case (i_dec.op)
            OP_BEQ:  taken = (a == b);
            OP_BNE:  taken = (a != b);
            OP_B:    taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // no predictor, so every taken branch redirects
    assign o_redirect.valid  = i_dec.valid && taken;
    assign o_redirect.target = i_dec.pc + i_dec.imm;

    // writeback, same edge as the commit
    assign o_we    = i_dec.valid && i_dec.we;
    assign o_waddr = i_dec.rd;
    assign o_wdata = alu_res;

    always_comb begin
        commit_d.valid = i_dec.valid;
        commit_d.pc    = i_dec.pc;
        commit_d.we    = i_dec.we;
        commit_d.rd    = i_dec.rd;
        commit_d.wdata = alu_res;
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= commit_d.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_dec.valid) begin
            commit_q <= commit_d;
        end
    end

    always_comb begin
        o_commit       = commit_q;
        o_commit.valid = valid_q;
    end

endmodule

//--- fetch/fetch_unit.sv
module fetch_unit
    import la_isa_pkg::*;
    import axi_lite_pkg::*;
#(
    parameter word_t RESET_PC = 32'h1C00_0000
) (
    input  logic      i_clk,
    input  logic      i_arst_n,
    input  redirect_t i_redirect,
    output axil_ar_t  o_ar,
    input  logic      i_arready,
    input  axil_r_t   i_r,
    output logic      o_rready,
    output logic      o_instr_valid,
    output word_t     o_instr_pc,
    output word_t     o_instr,
    output logic      o_instr_err
);

    typedef enum logic [1:0] {
        IDLE,   // only after reset
        ADDR,   // ar.valid up, waiting for arready
        DATA    // one read outstanding
    } fetch_state_e;

    fetch_state_e state_q, state_d;
    word_t        pc_q, pc_d;       // address of the current read
    word_t        tgt_q;            // redirect target held over a stale read
    logic         stale_q, stale_d;
    logic         ar_fire;
    logic         r_fire;
    logic         take_beat;

    assign ar_fire   = (state_q == ADDR) && i_arready;
    assign r_fire    = (state_q == DATA) && i_r.valid;
    assign take_beat = r_fire && !stale_q && !i_redirect.valid;

    assign o_ar     = '{valid: (state_q == ADDR), addr: pc_q, prot: AXIL_PROT_IFETCH};
    assign o_rready = (state_q == DATA);

    ////////////////////////////////////////////////////////////////////////////
    // read FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        pc_d    = pc_q;
        stale_d = stale_q;
        case (state_q)
            IDLE: begin
                state_d = ADDR;
            end
            ADDR: begin
                if (ar_fire) begin
                    state_d = DATA;
                end
                // addr must hold until accepted, so swallow the beat later
                if (i_redirect.valid) begin
                    stale_d = 1'b1;
                end
            end
            DATA: begin
                if (r_fire) begin
                    state_d = ADDR;
                    stale_d = 1'b0;
                    if (i_redirect.valid) begin
                        pc_d = i_redirect.target;   // beat is wrong path, dropped
                    end else if (stale_q) begin
                        pc_d = tgt_q;
                    end else begin
                        pc_d = pc_q + 32'd4;
                    end
                end else if (i_redirect.valid) begin
                    stale_d = 1'b1;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q       <= IDLE;
            pc_q          <= RESET_PC;
            stale_q       <= 1'b0;
            o_instr_valid <= 1'b0;
        end else begin
            state_q       <= state_d;
            pc_q          <= pc_d;
            stale_q       <= stale_d;
            o_instr_valid <= take_beat;   // one cycle per good beat
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_redirect.valid) begin
            tgt_q <= i_redirect.target;
        end
    end

    // instruction register towards decode
    always_ff @(posedge i_clk) begin
        if (r_fire) begin
            o_instr     <= i_r.data;
            o_instr_pc  <= pc_q;
            o_instr_err <= (i_r.resp != OKAY);
        end
    end

endmodule

//--- la_core.f
common/la_isa_pkg.sv
common/axi_lite_pkg.sv
logic/reg_file.sv
fetch/fetch_unit.sv
decode/decode_stage.sv
execute/execute_stage.sv
logic/la_core.sv
tests/axi_lite_rom.sv
tests/la_core_tb.sv

//--- logic/la_core.sv
module la_core
    import la_isa_pkg::*;
    import axi_lite_pkg::*;
#(
    parameter word_t RESET_PC = 32'h1C00_0000
) (
    input  logic     i_clk,
    input  logic     i_arst_n,
    output axil_ar_t o_ar,
    input  logic     i_arready,
    input  axil_r_t  i_r,
    output logic     o_rready,
    output commit_t  o_commit
);

    // fetch to decode
    logic      instr_valid;
    word_t     instr_pc;
    word_t     instr;
    logic      instr_err;

    decoded_t  dec;
    redirect_t redirect;    // taken branch from execute

    // register file ports
    reg_idx_t  raddr_a;
    reg_idx_t  raddr_b;
    word_t     rdata_a;
    word_t     rdata_b;
    logic      rf_we;
    reg_idx_t  rf_waddr;
    word_t     rf_wdata;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) fetch_unit_inst (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_redirect   (redirect),
        .o_ar         (o_ar),
        .i_arready    (i_arready),
        .i_r          (i_r),
        .o_rready     (o_rready),
        .o_instr_valid(instr_valid),
        .o_instr_pc   (instr_pc),
        .o_instr      (instr),
        .o_instr_err  (instr_err)
    );

    decode_stage decode_stage_inst (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_instr_valid(instr_valid),
        .i_instr_pc   (instr_pc),
        .i_instr      (instr),
        .i_instr_err  (instr_err),
        .i_redirect   (redirect),
        .o_raddr_a    (raddr_a),
        .o_raddr_b    (raddr_b),
        .i_rdata_a    (rdata_a),
        .i_rdata_b    (rdata_b),
        .o_dec        (dec)
    );

    reg_file reg_file_inst (
        .i_clk    (i_clk),
        .i_raddr_a(raddr_a),
        .i_raddr_b(raddr_b),
        .o_rdata_a(rdata_a),
        .o_rdata_b(rdata_b),
        .i_we     (rf_we),
        .i_waddr  (rf_waddr),
        .i_wdata  (rf_wdata)
    );

    execute_stage execute_stage_inst (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_dec     (dec),
        .o_redirect(redirect),
        .o_we      (rf_we),
        .o_waddr   (rf_waddr),
        .o_wdata   (rf_wdata),
        .o_commit  (o_commit)
    );

endmodule

//--- logic/reg_file.sv
module reg_file
    import la_isa_pkg::*;
(
    input  logic     i_clk,
    input  reg_idx_t i_raddr_a,
    input  reg_idx_t i_raddr_b,
    output word_t    o_rdata_a,
    output word_t    o_rdata_b,
    input  logic     i_we,
    input  reg_idx_t i_waddr,
    input  word_t    i_wdata
);

    word_t regs [NUM_REGS];

    // r0 reads as zero, a same-cycle write wins over the array
    function automatic word_t read_port(input reg_idx_t addr);
        word_t data;
        if (addr == '0) begin
            data = '0;
        end else if (i_we && (addr == i_waddr)) begin
            data = i_wdata;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        o_rdata_a = read_port(i_raddr_a);
        o_rdata_b = read_port(i_raddr_b);
    end

    always_ff @(posedge i_clk) begin
        if (i_we && (i_waddr != '0)) begin
            regs[i_waddr] <= i_wdata;
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the la_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f la_core.f --top-module la_core_tb \
    -o la_core_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/la_core_sim > sim.log 2>&1

grep -q ">>> FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"

//--- tests/axi_lite_rom.sv
module axi_lite_rom
    import axi_lite_pkg::*;
#(
    parameter logic [31:0] BASE  = 32'h1C00_0000,
    parameter int          DEPTH = 64
) (
    input  logic     i_clk,
    input  logic     i_arst_n,
    input  logic     i_rand_en,
    input  axil_ar_t i_ar,
    output logic     o_arready,
    output axil_r_t  o_r,
    input  logic     i_rready
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem [DEPTH];    // loaded by the testbench
    logic [31:0] addr_q;
    logic [31:0] idx;
    logic        busy;
    int          ar_wait;
    int          r_wait;
    integer      seed = 32'h2063_fd78;

    assign idx = (addr_q - BASE) >> 2;

    always @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_arready <= 1'b0;
            o_r       <= '{valid: 1'b0, data: 32'h0, resp: OKAY};
            busy      <= 1'b0;
            ar_wait   <= 0;
            r_wait    <= 0;
        end else if (!busy) begin
            if (o_arready && i_ar.valid) begin
                o_arready <= 1'b0;
                busy      <= 1'b1;
                addr_q    <= i_ar.addr;
                r_wait    <= i_rand_en ? ($random(seed) & 3) : 0;
            end else if (i_ar.valid) begin
                if (ar_wait == 0) o_arready <= 1'b1;
                else ar_wait <= ar_wait - 1;
            end
        end else if (o_r.valid && i_rready) begin
            o_r.valid <= 1'b0;
            busy      <= 1'b0;
            ar_wait   <= i_rand_en ? ($random(seed) & 3) : 0;
            // sometimes ready before the next address shows up
            o_arready <= i_rand_en && (($random(seed) & 3) == 0);
        end else if (!o_r.valid) begin
            if (r_wait == 0) begin
                o_r.valid <= 1'b1;
                // outside the array answers with a decode error
                o_r.data  <= (addr_q >= BASE && idx < DEPTH) ? mem[idx] : 32'h0;
                o_r.resp  <= (addr_q >= BASE && idx < DEPTH) ? OKAY : DECERR;
            end else begin
                r_wait <= r_wait - 1;
            end
        end
    end

endmodule

//--- tests/la_core_tb.sv
module la_core_tb
    import la_isa_pkg::*;
    import axi_lite_pkg::*;
;

    timeunit 1ns;
    timeprecision 1ps;

    localparam word_t RESET_PC  = 32'h1C00_0000;
    localparam int    TOTAL_LEN = 11 + 9 + 14 + 7 + 14 + 11;   // all programs run

    logic     clk;
    logic     arst_n;
    logic     rand_en;
    axil_ar_t ar;
    logic     arready;
    axil_r_t  r;
    logic     rready;
    commit_t  commit;

    word_t    prog [64];
    int       prog_len;
    commit_t  expected [$];
    int       err_count;
    int       test_count;
    int       test_fail;

    la_core #(.RESET_PC(RESET_PC)) la_core_inst (
        .i_clk(clk), .i_arst_n(arst_n), .o_ar(ar), .i_arready(arready),
        .i_r(r), .o_rready(rready), .o_commit(commit)
    );

    axi_lite_rom #(.BASE(RESET_PC), .DEPTH(64)) rom_inst (
        .i_clk(clk), .i_arst_n(arst_n), .i_rand_en(rand_en), .i_ar(ar),
        .o_arready(arready), .o_r(r), .i_rready(rready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // LA32R encoders
    ////////////////////////////////////////////////////////////////////////////

    function automatic word_t enc_3r(logic [16:0] opc, int rd, int rj, int rk);
        return {opc, rk[4:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic word_t enc_ri12(logic [9:0] opc, int rd, int rj, logic [11:0] imm);
        return {opc, imm, rj[4:0], rd[4:0]};
    endfunction

    function automatic word_t enc_lu12i(int rd, logic [19:0] si20);
        return {7'b0001010, si20, rd[4:0]};
    endfunction

    // offsets are in words
    function automatic word_t enc_cbr(logic [5:0] opc, int rj, int rd, logic [15:0] offs);
        return {opc, offs, rj[4:0], rd[4:0]};
    endfunction

    function automatic word_t enc_b(logic [25:0] offs);
        return {6'b010100, offs[15:0], offs[25:16]};
    endfunction

    task automatic put(input word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    // ISA model, walks the program until the jump to itself
    task automatic build_expected();
        word_t    gpr [32];
        word_t    pc, ins, a, b, res, nxt, boff;
        reg_idx_t rd;
        logic     we;
        expected.delete();
        foreach (gpr[i]) gpr[i] = '0;
        pc = RESET_PC;
        for (int step = 0; step < 200; step++) begin
            ins  = prog[(pc - RESET_PC) >> 2];
            rd   = ins[4:0];
            a    = gpr[ins[9:5]];
            b    = gpr[ins[14:10]];
            boff = {{14{ins[25]}}, ins[25:10], 2'b00};
            res  = '0;
            we   = 1'b1;
            nxt  = pc + 32'd4;
            if (ins[31:26] == 6'b010100) begin
                we  = 1'b0;
                nxt = pc + {{4{ins[9]}}, ins[9:0], ins[25:10], 2'b00};
            end else if (ins[31:26] == 6'b010110) begin
                we = 1'b0;
                if (a == gpr[rd]) nxt = pc + boff;
            end else if (ins[31:26] == 6'b010111) begin
                we = 1'b0;
                if (a != gpr[rd]) nxt = pc + boff;
            end else if (ins[31:25] == 7'b0001010) res = {ins[24:5], 12'b0};
            else if (ins[31:22] == 10'h00a) res = a + {{20{ins[21]}}, ins[21:10]};
            else if (ins[31:22] == 10'h00e) res = a | {20'b0, ins[21:10]};
            else begin
                case (ins[31:15])
                    17'h20:  res = a + b;
                    17'h22:  res = a - b;
                    17'h24:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    17'h29:  res = a & b;
                    17'h2a:  res = a | b;
                    17'h2b:  res = a ^ b;
                    default: we = 1'b0;   // illegal
                endcase
            end
            if (rd == '0) we = 1'b0;
            if (we) gpr[rd] = res;
            expected.push_back('{valid: 1'b1, pc: pc, we: we, rd: rd, wdata: res});
            if (ins == enc_b(26'd0)) break;
            pc = nxt;
        end
    endtask

    task automatic check_commit(input commit_t exp, input commit_t got);
        if (got.pc !== exp.pc) begin
            $display("[FAIL] commit.pc exp %h got %h", exp.pc, got.pc);
            err_count++;
        end else if (got.we !== exp.we) begin
            $display("[FAIL] commit.we at %h exp %h got %h", exp.pc, exp.we, got.we);
            err_count++;
        end else if (exp.we && (got.rd !== exp.rd || got.wdata !== exp.wdata)) begin
            $display("[FAIL] commit.rd/wdata at %h exp %h/%h got %h/%h",
                     exp.pc, exp.rd, exp.wdata, got.rd, got.wdata);
            err_count++;
        end
    endtask

    task automatic check_ar(input axil_ar_t exp, input axil_ar_t got);
        if (got !== exp) begin
            $display("[FAIL] ar addr/prot exp %h/%h got %h/%h",
                     exp.addr, exp.prot, got.addr, got.prot);
            err_count++;
        end
    endtask

    // rready follows the read that the bus handshakes left open
    task automatic check_rready(input logic exp, input logic got);
        if (got !== exp) begin
            $display("[FAIL] rready exp %h got %h", exp, got);
            err_count++;
        end
    endtask

    task automatic run_program(input string name, input logic rnd, input logic check_ars);
        word_t fa;
        int    errs_before, ar_idx, cycles, n;
        logic  done;
        logic  outstanding;
        errs_before = err_count;
        build_expected();
        @(posedge clk);
        arst_n  <= 1'b0;
        rand_en <= rnd;
        for (int i = 0; i < 64; i++) begin
            fa = RESET_PC + 4 * i;
            rom_inst.mem[i] = (i < prog_len) ? prog[i] :
                              (32'hFC00_0000 | ((fa ^ (fa >> 13)) & 32'h03FF_FFFF));
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        if (commit.valid !== 1'b0 || ar.valid !== 1'b0 || rready !== 1'b0) begin
            $display("commit, read address or rready valid while reset is held");
            err_count++;
        end
        @(posedge clk);
        arst_n <= 1'b1;
        ar_idx      = 0;
        cycles      = 0;
        n           = 0;
        done        = 1'b0;
        outstanding = 1'b0;
        while (!done && cycles < prog_len * 40) begin
            @(negedge clk);
            cycles++;
            check_rready(outstanding, rready);
            if (ar.valid && arready) outstanding = 1'b1;
            if (r.valid && rready) outstanding = 1'b0;
            if (commit.valid) begin
                n++;
                check_commit(expected.pop_front(), commit);
                done = (expected.size() == 0);
            end
            if (!done && check_ars && ar.valid && arready) begin
                check_ar('{valid: 1'b1, addr: RESET_PC + 4 * ar_idx, prot: 3'b101}, ar);
                ar_idx++;
            end
        end
        if (!done) begin
            $display("%s: end marker did not commit within %0d cycles", name, cycles);
            err_count++;
        end
        test_count++;
        if (err_count != errs_before) test_fail++;
        $display("test %-12s %0d commits, %0d errors", name, n, err_count - errs_before);
    endtask

    task automatic load_alu();
        prog_len = 0;
        put(enc_lu12i(1, 20'h12345));
        put(enc_ri12(10'h00e, 1, 1, 12'h678));
        put(enc_ri12(10'h00a, 2, 0, 12'hFFB));    // -5
        put(enc_3r(17'h20, 3, 1, 2));
        put(enc_3r(17'h22, 4, 2, 1));
        put(enc_3r(17'h29, 5, 1, 3));
        put(enc_3r(17'h2a, 6, 2, 1));
        put(enc_3r(17'h2b, 7, 3, 4));
        put(enc_3r(17'h24, 8, 2, 1));
        put(enc_3r(17'h24, 9, 1, 2));
        put(enc_b(26'd0));
    endtask

    task automatic load_chain();
        prog_len = 0;
        put(enc_ri12(10'h00a, 1, 0, 12'h001));
        for (int i = 0; i < 5; i++) put(enc_3r(17'h20, 1, 1, 1));   // doubling
        put(enc_3r(17'h22, 2, 1, 1));
        put(enc_ri12(10'h00a, 3, 1, 12'h007));
        put(enc_b(26'd0));
    endtask

    task automatic load_branch();
        prog_len = 0;
        put(enc_ri12(10'h00a, 1, 0, 12'h003));
        put(enc_ri12(10'h00a, 2, 0, 12'h003));
        put(enc_cbr(6'b010110, 1, 2, 16'd2));     // beq taken
        put(enc_ri12(10'h00a, 3, 0, 12'h111));
        put(enc_cbr(6'b010111, 1, 2, 16'd2));     // bne not taken
        put(enc_ri12(10'h00a, 4, 0, 12'h022));
        put(enc_cbr(6'b010111, 1, 4, 16'd3));
        put(enc_ri12(10'h00a, 5, 0, 12'h001));
        put(enc_ri12(10'h00a, 6, 0, 12'h002));
        put(enc_b(26'd2));
        put(enc_ri12(10'h00a, 7, 0, 12'h003));
        put(enc_cbr(6'b010110, 1, 4, 16'd2));     // beq not taken
        put(enc_ri12(10'h00a, 8, 0, 12'hFFF));
        put(enc_b(26'd0));
    endtask

    task automatic load_r0_illegal();
        prog_len = 0;
        put(enc_ri12(10'h00a, 0, 0, 12'h055));
        put(enc_lu12i(0, 20'hFFFFF));
        put(enc_3r(17'h20, 5, 0, 0));
        put(32'h0000_0000);
        put(32'hFFFF_FFFF);
        put(enc_ri12(10'h00e, 6, 0, 12'hABC));
        put(enc_b(26'd0));
    endtask

    // watchdog
    initial begin
        repeat (TOTAL_LEN * 40 + 6 * 20) @(posedge clk);
        $display("watchdog expired, the run did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        arst_n     = 1'b0;
        rand_en    = 1'b0;
        err_count  = 0;
        test_count = 0;
        test_fail  = 0;
        load_alu();
        run_program("alu", 1'b0, 1'b1);
        load_chain();
        run_program("chain", 1'b0, 1'b1);
        load_branch();
        run_program("branch", 1'b0, 1'b0);
        load_r0_illegal();
        run_program("r0_illegal", 1'b0, 1'b0);
        load_branch();
        run_program("branch_rnd", 1'b1, 1'b0);
        load_alu();
        run_program("alu_rnd", 1'b1, 1'b0);
        $display("tests %0d, failed tests %0d, failed checks %0d",
                 test_count, test_fail, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
